/* common/rv_dec_pkg.sv */
/*
  Shared widths, encodings and state types of the RV32I decode stage.
  Only RV32I base opcodes are listed. Branch, jump, fence and system
  opcodes are named so that the decoder can recognise them, but the
  stage reports them as illegal.
  The sequencer needs nine states, so its type is 4 bits wide.
*/
package rv_dec_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int XLEN       = 32;
  localparam int REG_AW     = 5;
  localparam int ALU_OP_W   = 4;
  localparam int LSU_CTRL_W = 4;

  ////////////////////
  // Major opcodes
  ////////////////////
  typedef enum logic [6:0] {
    OP_LOAD    = 7'b0000011,
    OP_MISCMEM = 7'b0001111, // Not supported
    OP_OPIMM   = 7'b0010011,
    OP_AUIPC   = 7'b0010111,
    OP_STORE   = 7'b0100011,
    OP_OP      = 7'b0110011,
    OP_LUI     = 7'b0110111,
    OP_BRANCH  = 7'b1100011, // Not supported
    OP_JALR    = 7'b1100111, // Not supported
    OP_JAL     = 7'b1101111, // Not supported
    OP_SYSTEM  = 7'b1110011  // Not supported
  } opcode_e;

  // ALU select is {funct7[5], funct3}
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  localparam logic [2:0] FUNCT3_SHIFT_L = 3'b001;
  localparam logic [2:0] FUNCT3_SHIFT_R = 3'b101;

  ////////////////////
  // Sequencer
  ////////////////////
  typedef enum logic [3:0] {
    S_IDLE     = 4'd0,
    S_STALL    = 4'd1,
    S_LD_ADDR  = 4'd2,
    S_LD_REQ   = 4'd3,
    S_LD_WAIT0 = 4'd4,
    S_LD_WAIT1 = 4'd5,
    S_LD_WAIT2 = 4'd6,
    S_ST_ADDR  = 4'd7,
    S_ST_REQ   = 4'd8
  } seq_state_e;

  typedef enum logic [2:0] {
    CL_ALU     = 3'd0,
    CL_UPPER   = 3'd1,
    CL_LOAD    = 3'd2,
    CL_STORE   = 3'd3,
    CL_ILLEGAL = 3'd4
  } instr_class_e;

endpackage

/* rtl/imm_gen.sv */
/*
  Immediate builder for the I, shift, S and U formats.
  Purely combinational. The shift amount is zero-extended, since
  shamt is an unsigned field. The other immediates are sign-extended
  from instruction bit 31.
*/
`timescale 1ns/10ps

module imm_gen (
  input  logic [rv_dec_pkg::XLEN-1:0] instr_i,
  output logic [rv_dec_pkg::XLEN-1:0] imm_i_o,
  output logic [rv_dec_pkg::XLEN-1:0] imm_sh_o,
  output logic [rv_dec_pkg::XLEN-1:0] imm_s_o,
  output logic [rv_dec_pkg::XLEN-1:0] imm_u_o
);

  logic sign;

  assign sign = instr_i[31];

  // I-type, instr[31:20]
  assign imm_i_o = {{(rv_dec_pkg::XLEN-12){sign}}, instr_i[31:20]};

  // Shift amount sits in the rs2 position
  assign imm_sh_o = {{(rv_dec_pkg::XLEN-5){1'b0}}, instr_i[24:20]};

  // S-type, upper bits from funct7 field, lower from rd field
  assign imm_s_o = {{(rv_dec_pkg::XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};

  // U-type, low 12 bits zero-filled
  assign imm_u_o = {instr_i[31:12], 12'b0};

endmodule

/* rtl/hazard_unit.sv */
/*
  Read-after-write check against the instruction completed just before.
  Only one destination is tracked, so a dependency two instructions
  apart is not detected. The stall request is combinational and only
  raised in S_IDLE, so any dependency costs exactly one cycle.
*/
`timescale 1ns/10ps

module hazard_unit (
  input  logic                         clk_i,
  input  logic                         rstn_i,
  input  logic [rv_dec_pkg::XLEN-1:0]  instr_i,
  input  rv_dec_pkg::instr_class_e     instr_class_i,
  input  logic                         done_i,
  input  rv_dec_pkg::seq_state_e       state_i,
  output logic                         stall_req_o
);

  logic [rv_dec_pkg::REG_AW-1:0] rd;
  logic [rv_dec_pkg::REG_AW-1:0] rs1;
  logic [rv_dec_pkg::REG_AW-1:0] rs2;
  logic [rv_dec_pkg::REG_AW-1:0] last_rd_q;
  logic                          writes_rd;
  logic                          reads_rs1;
  logic                          reads_rs2;
  logic                          hit_rs1;
  logic                          hit_rs2;

  assign rd  = instr_i[11:7];
  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];

  assign writes_rd = (instr_class_i == rv_dec_pkg::CL_ALU)   ||
                     (instr_class_i == rv_dec_pkg::CL_UPPER) ||
                     (instr_class_i == rv_dec_pkg::CL_LOAD);

  // Upper and illegal instructions read no source register
  assign reads_rs1 = (instr_class_i == rv_dec_pkg::CL_ALU)  ||
                     (instr_class_i == rv_dec_pkg::CL_LOAD) ||
                     (instr_class_i == rv_dec_pkg::CL_STORE);
  assign reads_rs2 = (instr_i[6:0] == rv_dec_pkg::OP_OP) ||
                     (instr_i[6:0] == rv_dec_pkg::OP_STORE);

  assign hit_rs1 = reads_rs1 && (rs1 != '0) && (rs1 == last_rd_q);
  assign hit_rs2 = reads_rs2 && (rs2 != '0) && (rs2 == last_rd_q);

  assign stall_req_o = (state_i == rv_dec_pkg::S_IDLE) && (hit_rs1 || hit_rs2);

  ////////////////////
  // Last destination
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_rd_q <= '0;
    end else if (done_i) begin
      last_rd_q <= writes_rd ? rd : '0; // Stores and illegals clear it
    end
  end

endmodule

/* rtl/mem_seq.sv */
/*
  Step sequencer for the decode stage.
  next_state_o names the step executed in the current cycle. The state
  register returns to S_IDLE after the last step of every instruction,
  so each new instruction is dispatched from S_IDLE.
  The FSM only advances on edges where instr_valid_i is high.
*/
`timescale 1ns/10ps

module mem_seq (
  input  logic                      clk_i,
  input  logic                      rstn_i,
  input  logic                      instr_valid_i,
  input  rv_dec_pkg::instr_class_e  instr_class_i,
  input  logic                      stall_req_i,
  output rv_dec_pkg::seq_state_e    state_o,
  output rv_dec_pkg::seq_state_e    next_state_o,
  output logic                      ready_o,
  output logic                      done_o
);

  rv_dec_pkg::seq_state_e state_q;
  rv_dec_pkg::seq_state_e state_d;
  logic                   last_step;

  ////////////////////
  // Next step
  ////////////////////
  always_comb begin
    state_d = rv_dec_pkg::S_IDLE;
    case (state_q)
      rv_dec_pkg::S_IDLE,
      rv_dec_pkg::S_STALL: begin
        if (stall_req_i) begin
          state_d = rv_dec_pkg::S_STALL;
        end else if (instr_class_i == rv_dec_pkg::CL_LOAD) begin
          state_d = rv_dec_pkg::S_LD_ADDR;
        end else if (instr_class_i == rv_dec_pkg::CL_STORE) begin
          state_d = rv_dec_pkg::S_ST_ADDR;
        end else begin
          state_d = rv_dec_pkg::S_IDLE; // Single cycle ALU, upper or illegal
        end
      end
      rv_dec_pkg::S_LD_ADDR:  state_d = rv_dec_pkg::S_LD_REQ;
      rv_dec_pkg::S_LD_REQ:   state_d = rv_dec_pkg::S_LD_WAIT0;
      rv_dec_pkg::S_LD_WAIT0: state_d = rv_dec_pkg::S_LD_WAIT1;
      rv_dec_pkg::S_LD_WAIT1: state_d = rv_dec_pkg::S_LD_WAIT2;
      rv_dec_pkg::S_ST_ADDR:  state_d = rv_dec_pkg::S_ST_REQ;
      default:                state_d = rv_dec_pkg::S_IDLE;
    endcase
  end

  // Final step of each instruction type
  assign last_step = (state_d == rv_dec_pkg::S_IDLE)     ||
                     (state_d == rv_dec_pkg::S_LD_WAIT2) ||
                     (state_d == rv_dec_pkg::S_ST_REQ);

  assign ready_o      = last_step;
  assign done_o       = last_step && instr_valid_i; // Completing edge
  assign next_state_o = state_d;
  assign state_o      = state_q;

  ////////////////////
  // State register
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= rv_dec_pkg::S_IDLE;
    end else if (instr_valid_i) begin
      state_q <= last_step ? rv_dec_pkg::S_IDLE : state_d;
    end
  end

endmodule

/* rtl/ctrl_decode.sv */
/*
  Opcode classification and control generation, one register stage.
  Controls are chosen for the step given by next_state_i. Only funct7
  bit 30 is looked at, other funct7 bits are not checked for legality.
  With instr_valid_i low the strobes are cleared and the rest holds.
*/
`timescale 1ns/10ps

module ctrl_decode (
  input  logic                               clk_i,
  input  logic                               rstn_i,
  input  logic [rv_dec_pkg::XLEN-1:0]        instr_i,
  input  logic                               instr_valid_i,
  input  rv_dec_pkg::seq_state_e             next_state_i,
  input  logic [rv_dec_pkg::XLEN-1:0]        imm_i_i,
  input  logic [rv_dec_pkg::XLEN-1:0]        imm_sh_i,
  input  logic [rv_dec_pkg::XLEN-1:0]        imm_s_i,
  input  logic [rv_dec_pkg::XLEN-1:0]        imm_u_i,
  output rv_dec_pkg::instr_class_e           instr_class_o,
  output logic                               illegal_instr_o,
  output rv_dec_pkg::alu_op_e                alu_sel_o,
  output logic                               alu_op_a_o,
  output logic                               alu_op_b_o,
  output logic                               use_pc_o,
  output logic [rv_dec_pkg::REG_AW-1:0]      alu_dest_addr_o,
  output logic                               alu_wb_o,
  output logic [rv_dec_pkg::REG_AW-1:0]      rf_addr_a_o,
  output logic [rv_dec_pkg::REG_AW-1:0]      rf_addr_b_o,
  output logic                               is_imm_o,
  output logic [rv_dec_pkg::XLEN-1:0]        imm_ext_o,
  output logic                               lsu_ctrl_valid_o,
  output logic [rv_dec_pkg::LSU_CTRL_W-1:0]  lsu_ctrl_o,
  output logic [rv_dec_pkg::REG_AW-1:0]      lsu_regdest_o
);

  rv_dec_pkg::opcode_e             opcode;
  logic [2:0]                      funct3;
  logic [rv_dec_pkg::REG_AW-1:0]   rd;
  logic [rv_dec_pkg::REG_AW-1:0]   rs1;
  logic [rv_dec_pkg::REG_AW-1:0]   rs2;
  logic                            is_shift;

  // Values for the next register stage
  logic                            illegal_d;
  rv_dec_pkg::alu_op_e             alu_sel_d;
  logic                            op_a_d;
  logic                            op_b_d;
  logic                            use_pc_d;
  logic [rv_dec_pkg::REG_AW-1:0]   dest_d;
  logic                            wb_d;
  logic [rv_dec_pkg::REG_AW-1:0]   rf_a_d;
  logic [rv_dec_pkg::REG_AW-1:0]   rf_b_d;
  logic                            is_imm_d;
  logic [rv_dec_pkg::XLEN-1:0]     imm_d;
  logic                            lsu_valid_d;
  logic [rv_dec_pkg::LSU_CTRL_W-1:0] lsu_ctrl_d;
  logic [rv_dec_pkg::REG_AW-1:0]   lsu_regdest_d;

  assign opcode   = rv_dec_pkg::opcode_e'(instr_i[6:0]);
  assign funct3   = instr_i[14:12];
  assign rd       = instr_i[11:7];
  assign rs1      = instr_i[19:15];
  assign rs2      = instr_i[24:20];
  assign is_shift = (funct3 == rv_dec_pkg::FUNCT3_SHIFT_L) ||
                    (funct3 == rv_dec_pkg::FUNCT3_SHIFT_R);

  ////////////////////
  // Classification
  ////////////////////
  always_comb begin
    case (opcode)
      rv_dec_pkg::OP_OP,
      rv_dec_pkg::OP_OPIMM: instr_class_o = rv_dec_pkg::CL_ALU;
      rv_dec_pkg::OP_LUI,
      rv_dec_pkg::OP_AUIPC: instr_class_o = rv_dec_pkg::CL_UPPER;
      rv_dec_pkg::OP_LOAD:  instr_class_o = rv_dec_pkg::CL_LOAD;
      rv_dec_pkg::OP_STORE: instr_class_o = rv_dec_pkg::CL_STORE;
      // Control flow, fence and system are known but unsupported
      rv_dec_pkg::OP_BRANCH,
      rv_dec_pkg::OP_JAL,
      rv_dec_pkg::OP_JALR,
      rv_dec_pkg::OP_MISCMEM,
      rv_dec_pkg::OP_SYSTEM: instr_class_o = rv_dec_pkg::CL_ILLEGAL;
      default:               instr_class_o = rv_dec_pkg::CL_ILLEGAL;
    endcase
  end

  ////////////////////
  // Step controls
  ////////////////////
  always_comb begin
    illegal_d     = 1'b0;
    alu_sel_d     = rv_dec_pkg::ALU_ADD;
    op_a_d        = 1'b0;
    op_b_d        = 1'b0;
    use_pc_d      = 1'b0;
    dest_d        = '0;
    wb_d          = 1'b0;
    rf_a_d        = '0;
    rf_b_d        = '0;
    is_imm_d      = 1'b0;
    imm_d         = '0;
    lsu_valid_d   = 1'b0;
    lsu_ctrl_d    = '0;
    lsu_regdest_d = '0;

    case (next_state_i)
      rv_dec_pkg::S_IDLE: begin
        case (instr_class_o)
          rv_dec_pkg::CL_ALU: begin
            op_a_d = 1'b1;
            rf_a_d = rs1;
            dest_d = rd;
            wb_d   = 1'b1;
            if (opcode == rv_dec_pkg::OP_OP) begin
              op_b_d    = 1'b1;
              rf_b_d    = rs2;
              alu_sel_d = rv_dec_pkg::alu_op_e'({instr_i[30], funct3});
            end else if (is_shift) begin
              is_imm_d  = 1'b1;
              imm_d     = imm_sh_i;
              alu_sel_d = rv_dec_pkg::alu_op_e'({instr_i[30], funct3}); // SRAI keeps bit 30
            end else begin
              is_imm_d  = 1'b1;
              imm_d     = imm_i_i;
              alu_sel_d = rv_dec_pkg::alu_op_e'({1'b0, funct3});
            end
          end
          rv_dec_pkg::CL_UPPER: begin
            op_a_d   = 1'b1; // x0 for LUI, pc for AUIPC
            use_pc_d = (opcode == rv_dec_pkg::OP_AUIPC);
            is_imm_d = 1'b1;
            imm_d    = imm_u_i;
            dest_d   = rd;
            wb_d     = 1'b1;
          end
          rv_dec_pkg::CL_ILLEGAL: illegal_d = 1'b1;
          default: ;
        endcase
      end
      // Effective address is rs1 plus offset
      rv_dec_pkg::S_LD_ADDR,
      rv_dec_pkg::S_ST_ADDR: begin
        op_a_d   = 1'b1;
        rf_a_d   = rs1;
        is_imm_d = 1'b1;
        imm_d    = (next_state_i == rv_dec_pkg::S_LD_ADDR) ? imm_i_i : imm_s_i;
      end
      rv_dec_pkg::S_LD_REQ,
      rv_dec_pkg::S_ST_REQ: begin
        lsu_valid_d = 1'b1;
        lsu_ctrl_d  = {instr_i[5], funct3}; // Store flag, width and sign
        if (next_state_i == rv_dec_pkg::S_LD_REQ) begin
          lsu_regdest_d = rd;
        end else begin
          rf_b_d = rs2; // Store data
        end
      end
      default: ; // Stall and load waits keep every strobe low
    endcase
  end

  ////////////////////
  // Output registers
  ////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      illegal_instr_o  <= 1'b0;
      alu_sel_o        <= rv_dec_pkg::ALU_ADD;
      alu_op_a_o       <= 1'b0;
      alu_op_b_o       <= 1'b0;
      use_pc_o         <= 1'b0;
      alu_dest_addr_o  <= '0;
      alu_wb_o         <= 1'b0;
      rf_addr_a_o      <= '0;
      rf_addr_b_o      <= '0;
      is_imm_o         <= 1'b0;
      imm_ext_o        <= '0;
      lsu_ctrl_valid_o <= 1'b0;
      lsu_ctrl_o       <= '0;
      lsu_regdest_o    <= '0;
    end else if (instr_valid_i) begin
      illegal_instr_o  <= illegal_d;
      alu_sel_o        <= alu_sel_d;
      alu_op_a_o       <= op_a_d;
      alu_op_b_o       <= op_b_d;
      use_pc_o         <= use_pc_d;
      alu_dest_addr_o  <= dest_d;
      alu_wb_o         <= wb_d;
      rf_addr_a_o      <= rf_a_d;
      rf_addr_b_o      <= rf_b_d;
      is_imm_o         <= is_imm_d;
      imm_ext_o        <= imm_d;
      lsu_ctrl_valid_o <= lsu_valid_d;
      lsu_ctrl_o       <= lsu_ctrl_d;
      lsu_regdest_o    <= lsu_regdest_d;
    end else begin
      illegal_instr_o  <= 1'b0;
      use_pc_o         <= 1'b0;
      alu_wb_o         <= 1'b0;
      lsu_ctrl_valid_o <= 1'b0;
    end
  end

endmodule

/* rtl/rv_decoder.sv */
/*
  RV32I decode stage top level.
  Fetch must hold instr_i stable while ready_o is low. An instruction
  completes on the edge where instr_valid_i and ready_o are both high.
  All control outputs are registered. ready_o is combinational.
*/
`timescale 1ns/10ps

module rv_decoder (
  input  logic                               clk_i,
  input  logic                               rstn_i,
  input  logic [rv_dec_pkg::XLEN-1:0]        instr_i,
  input  logic [rv_dec_pkg::XLEN-1:0]        instr_addr_i,
  input  logic                               instr_valid_i,
  output logic                               ready_o,
  output logic [rv_dec_pkg::XLEN-1:0]        instr_addr_o,
  output logic                               illegal_instr_o,
  output rv_dec_pkg::alu_op_e                alu_sel_o,
  output logic                               alu_op_a_o,
  output logic                               alu_op_b_o,
  output logic                               use_pc_o,
  output logic [rv_dec_pkg::REG_AW-1:0]      alu_dest_addr_o,
  output logic                               alu_wb_o,
  output logic [rv_dec_pkg::REG_AW-1:0]      rf_addr_a_o,
  output logic [rv_dec_pkg::REG_AW-1:0]      rf_addr_b_o,
  output logic                               is_imm_o,
  output logic [rv_dec_pkg::XLEN-1:0]        imm_ext_o,
  output logic                               lsu_ctrl_valid_o,
  output logic [rv_dec_pkg::LSU_CTRL_W-1:0]  lsu_ctrl_o,
  output logic [rv_dec_pkg::REG_AW-1:0]      lsu_regdest_o
);

  rv_dec_pkg::instr_class_e    instr_class;
  rv_dec_pkg::seq_state_e      state;
  rv_dec_pkg::seq_state_e      next_state;
  logic                        stall_req;
  logic                        done;
  logic [rv_dec_pkg::XLEN-1:0] imm_i;
  logic [rv_dec_pkg::XLEN-1:0] imm_sh;
  logic [rv_dec_pkg::XLEN-1:0] imm_s;
  logic [rv_dec_pkg::XLEN-1:0] imm_u;

  // Address follows the controls with one cycle of latency
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      instr_addr_o <= '0;
    end else begin
      instr_addr_o <= instr_addr_i;
    end
  end

  imm_gen u_imm_gen (
    .instr_i  (instr_i),
    .imm_i_o  (imm_i),
    .imm_sh_o (imm_sh),
    .imm_s_o  (imm_s),
    .imm_u_o  (imm_u)
  );

  hazard_unit u_hazard_unit (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_i       (instr_i),
    .instr_class_i (instr_class),
    .done_i        (done),
    .state_i       (state),
    .stall_req_o   (stall_req)
  );

  mem_seq u_mem_seq (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .instr_class_i (instr_class),
    .stall_req_i   (stall_req),
    .state_o       (state),
    .next_state_o  (next_state),
    .ready_o       (ready_o),
    .done_o        (done)
  );

  ctrl_decode u_ctrl_decode (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .instr_i          (instr_i),
    .instr_valid_i    (instr_valid_i),
    .next_state_i     (next_state),
    .imm_i_i          (imm_i),
    .imm_sh_i         (imm_sh),
    .imm_s_i          (imm_s),
    .imm_u_i          (imm_u),
    .instr_class_o    (instr_class),
    .illegal_instr_o  (illegal_instr_o),
    .alu_sel_o        (alu_sel_o),
    .alu_op_a_o       (alu_op_a_o),
    .alu_op_b_o       (alu_op_b_o),
    .use_pc_o         (use_pc_o),
    .alu_dest_addr_o  (alu_dest_addr_o),
    .alu_wb_o         (alu_wb_o),
    .rf_addr_a_o      (rf_addr_a_o),
    .rf_addr_b_o      (rf_addr_b_o),
    .is_imm_o         (is_imm_o),
    .imm_ext_o        (imm_ext_o),
    .lsu_ctrl_valid_o (lsu_ctrl_valid_o),
    .lsu_ctrl_o       (lsu_ctrl_o),
    .lsu_regdest_o    (lsu_regdest_o)
  );

endmodule

/* dv/tb_clkgen.sv */
/*
  Clock and reset source for the decode stage testbench.
  10 ns clock. Reset is active low and synchronous in the DUT, and
  it is held over the first three rising edges.
*/
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o; // 10 ns period
  end

  initial begin
    rstn_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rstn_o <= 1'b1; // Released after the third edge
  end

endmodule

/* dv/dec_model.svh */
/*
  Reference model of the decode stage outputs.
  One entry per clock cycle. Entries hold the registered controls seen
  after the rising edge and the ready value seen before it.
  Included inside the testbench module.
*/
`ifndef DEC_MODEL_SVH
`define DEC_MODEL_SVH

typedef struct packed {
  logic        chk_ready;   // Idle cycles leave ready unchecked
  logic        ready;
  logic        illegal;
  logic [3:0]  alu_sel;
  logic        op_a;
  logic        op_b;
  logic        use_pc;
  logic [4:0]  dest;
  logic        wb;
  logic [4:0]  rf_a;
  logic [4:0]  rf_b;
  logic        is_imm;
  logic [31:0] imm;
  logic        lsu_valid;
  logic [3:0]  lsu_ctrl;
  logic [4:0]  lsu_regdest;
  logic [31:0] addr;
} exp_t;

exp_t  exp_q[$];
string name_q[$];
exp_t  last_exp = '0; // Reset values

function automatic void push_step(input exp_t e, input string name);
  exp_q.push_back(e);
  name_q.push_back(name);
  last_exp = e;
endfunction

// Cycle with instr_valid low, strobes drop and the rest holds
function automatic exp_t gap_step(input logic [31:0] addr);
  exp_t e;
  e           = last_exp;
  e.chk_ready = 1'b0;
  e.ready     = 1'b0;
  e.illegal   = 1'b0;
  e.use_pc    = 1'b0;
  e.wb        = 1'b0;
  e.lsu_valid = 1'b0;
  e.addr      = addr;
  return e;
endfunction

function automatic void expand_instr(input logic [31:0] ins, input bit hazard,
                                     input logic [31:0] addr, input string name);
  exp_t        steps[6];
  exp_t        base;
  int          n;
  int          i;
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  opc            = ins[6:0];
  f3             = ins[14:12];
  imm_i          = {{20{ins[31]}}, ins[31:20]};
  imm_s          = {{20{ins[31]}}, ins[31:25], ins[11:7]};
  base           = '0; // Bubble, every control low
  base.chk_ready = 1'b1;
  base.addr      = addr;
  n              = 0;
  steps[0]       = base;
  if (hazard) begin
    n        = 1; // One stall bubble first
    steps[1] = base;
  end
  case (opc)
    rv_dec_pkg::OP_OP,
    rv_dec_pkg::OP_OPIMM: begin
      steps[n].op_a = 1'b1;
      steps[n].rf_a = ins[19:15];
      steps[n].dest = ins[11:7];
      steps[n].wb   = 1'b1;
      if (opc == rv_dec_pkg::OP_OP) begin
        steps[n].op_b    = 1'b1;
        steps[n].rf_b    = ins[24:20];
        steps[n].alu_sel = {ins[30], f3};
      end else if (f3 == 3'b001 || f3 == 3'b101) begin
        steps[n].is_imm  = 1'b1;
        steps[n].imm     = {27'b0, ins[24:20]}; // shamt
        steps[n].alu_sel = {ins[30], f3};
      end else begin
        steps[n].is_imm  = 1'b1;
        steps[n].imm     = imm_i;
        steps[n].alu_sel = {1'b0, f3};
      end
    end
    rv_dec_pkg::OP_LUI,
    rv_dec_pkg::OP_AUIPC: begin
      steps[n].op_a   = 1'b1;
      steps[n].use_pc = (opc == rv_dec_pkg::OP_AUIPC);
      steps[n].is_imm = 1'b1;
      steps[n].imm    = {ins[31:12], 12'b0};
      steps[n].dest   = ins[11:7];
      steps[n].wb     = 1'b1;
    end
    rv_dec_pkg::OP_LOAD,
    rv_dec_pkg::OP_STORE: begin
      steps[n].op_a   = 1'b1; // Address cycle
      steps[n].rf_a   = ins[19:15];
      steps[n].is_imm = 1'b1;
      steps[n].imm    = (opc == rv_dec_pkg::OP_LOAD) ? imm_i : imm_s;
      n               = n + 1;
      steps[n]           = base;
      steps[n].lsu_valid = 1'b1;
      steps[n].lsu_ctrl  = {ins[5], f3};
      if (opc == rv_dec_pkg::OP_LOAD) begin
        steps[n].lsu_regdest = ins[11:7];
        repeat (3) begin
          n        = n + 1;
          steps[n] = base; // Load wait
        end
      end else begin
        steps[n].rf_b = ins[24:20];
      end
    end
    default: steps[n].illegal = 1'b1;
  endcase
  steps[n].ready = 1'b1; // Only the final cycle
  for (i = 0; i <= n; i++) begin
    push_step(steps[i], name);
  end
endfunction

`endif

/* dv/rv_decoder_tb.sv */
/*
  Testbench for the RV32I decode stage.
  Inputs change on falling edges. Registered outputs are checked 1 ns
  after each rising edge, ready_o 2 ns after the falling edge.
  Random fields use $urandom, seed 85.
*/
`timescale 1ns/10ps

module rv_decoder_tb;

  localparam int NUM_INSTR = 46; // Instructions issued below
  localparam int CLK_NS    = 10;

  logic        clk;
  logic        rstn;
  logic [31:0] instr;
  logic [31:0] instr_addr;
  logic        instr_valid;
  logic        ready;
  logic [31:0] instr_addr_out;
  logic        illegal_instr;
  rv_dec_pkg::alu_op_e alu_sel;
  logic        alu_op_a;
  logic        alu_op_b;
  logic        use_pc;
  logic [4:0]  alu_dest_addr;
  logic        alu_wb;
  logic [4:0]  rf_addr_a;
  logic [4:0]  rf_addr_b;
  logic        is_imm;
  logic [31:0] imm_ext;
  logic        lsu_ctrl_valid;
  logic [3:0]  lsu_ctrl;
  logic [4:0]  lsu_regdest;

  int          errors  = 0;
  logic [4:0]  last_rd = '0; // Destination of the last completed instruction
  logic [31:0] pc      = 32'h0000_1000;

  `include "dec_model.svh"

  tb_clkgen u_clkgen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  rv_decoder dut (
    .clk_i            (clk),
    .rstn_i           (rstn),
    .instr_i          (instr),
    .instr_addr_i     (instr_addr),
    .instr_valid_i    (instr_valid),
    .ready_o          (ready),
    .instr_addr_o     (instr_addr_out),
    .illegal_instr_o  (illegal_instr),
    .alu_sel_o        (alu_sel),
    .alu_op_a_o       (alu_op_a),
    .alu_op_b_o       (alu_op_b),
    .use_pc_o         (use_pc),
    .alu_dest_addr_o  (alu_dest_addr),
    .alu_wb_o         (alu_wb),
    .rf_addr_a_o      (rf_addr_a),
    .rf_addr_b_o      (rf_addr_b),
    .is_imm_o         (is_imm),
    .imm_ext_o        (imm_ext),
    .lsu_ctrl_valid_o (lsu_ctrl_valid),
    .lsu_ctrl_o       (lsu_ctrl),
    .lsu_regdest_o    (lsu_regdest)
  );

  ////////////////////
  // Hazard tracking
  ////////////////////
  function automatic bit needs_stall(input logic [31:0] ins);
    logic [6:0] opc;
    bit         uses_rs1;
    bit         uses_rs2;
    opc      = ins[6:0];
    uses_rs1 = (opc == rv_dec_pkg::OP_OP) || (opc == rv_dec_pkg::OP_OPIMM) ||
               (opc == rv_dec_pkg::OP_LOAD) || (opc == rv_dec_pkg::OP_STORE);
    uses_rs2 = (opc == rv_dec_pkg::OP_OP) || (opc == rv_dec_pkg::OP_STORE);
    return (uses_rs1 && ins[19:15] != 5'd0 && ins[19:15] == last_rd) ||
           (uses_rs2 && ins[24:20] != 5'd0 && ins[24:20] == last_rd);
  endfunction

  function automatic bit writes_rd(input logic [31:0] ins);
    return (ins[6:0] == rv_dec_pkg::OP_OP) || (ins[6:0] == rv_dec_pkg::OP_OPIMM) ||
           (ins[6:0] == rv_dec_pkg::OP_LUI) || (ins[6:0] == rv_dec_pkg::OP_AUIPC) ||
           (ins[6:0] == rv_dec_pkg::OP_LOAD);
  endfunction

  ////////////////////
  // Drivers
  ////////////////////
  // Present one instruction and hold it until the ready edge
  task automatic issue(input logic [31:0] ins, input string name);
    bit accepted;
    expand_instr(ins, needs_stall(ins), pc, name);
    instr       = ins;
    instr_addr  = pc;
    instr_valid = 1'b1;
    last_rd     = writes_rd(ins) ? ins[11:7] : 5'd0;
    pc          = pc + 4;
    accepted    = 1'b0;
    while (!accepted) begin
      #1;
      accepted = ready;
      @(negedge clk);
    end
  endtask

  task automatic idle_gap(input int cycles, input string name);
    instr_valid = 1'b0;
    repeat (cycles) begin
      instr_addr = pc;
      push_step(gap_step(pc), name);
      pc = pc + 4;
      @(negedge clk);
    end
  endtask

  ////////////////////
  // Checking
  ////////////////////
  task automatic check_field(input string test, input string sig,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("error: %s %s expected 0x%0h actual 0x%0h", test, sig, exp, act);
    end
  endtask

  task automatic check_outputs(input exp_t e, input string name);
    check_field(name, "instr_addr_o", e.addr, instr_addr_out);
    check_field(name, "illegal_instr_o", e.illegal, illegal_instr);
    check_field(name, "alu_sel_o", e.alu_sel, alu_sel);
    check_field(name, "alu_op_a_o", e.op_a, alu_op_a);
    check_field(name, "alu_op_b_o", e.op_b, alu_op_b);
    check_field(name, "use_pc_o", e.use_pc, use_pc);
    check_field(name, "alu_dest_addr_o", e.dest, alu_dest_addr);
    check_field(name, "alu_wb_o", e.wb, alu_wb);
    check_field(name, "rf_addr_a_o", e.rf_a, rf_addr_a);
    check_field(name, "rf_addr_b_o", e.rf_b, rf_addr_b);
    check_field(name, "is_imm_o", e.is_imm, is_imm);
    check_field(name, "imm_ext_o", e.imm, imm_ext);
    check_field(name, "lsu_ctrl_valid_o", e.lsu_valid, lsu_ctrl_valid);
    check_field(name, "lsu_ctrl_o", e.lsu_ctrl, lsu_ctrl);
    check_field(name, "lsu_regdest_o", e.lsu_regdest, lsu_regdest);
  endtask

  initial begin : check_loop
    exp_t  e;
    string nm;
    forever begin
      @(negedge clk);
      #2;
      if (exp_q.size() > 0) begin
        e  = exp_q.pop_front();
        nm = name_q.pop_front();
        if (e.chk_ready) begin
          check_field(nm, "ready_o", e.ready, ready);
        end
        @(posedge clk);
        #1; // Registered outputs settled
        check_outputs(e, nm);
      end
    end
  end

  initial begin : watchdog
    #(CLK_NS * (NUM_INSTR * 6 + 20));
    $display("Timeout: run did not end within %0d cycles", NUM_INSTR * 6 + 20);
    $display("Errors: %0d", errors);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin : stimulus
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    int          k;
    void'($urandom(85));
    instr       = '0;
    instr_addr  = '0;
    instr_valid = 1'b0;
    @(posedge rstn);
    @(negedge clk);
    idle_gap(2, "reset_hold");

    // Sources from x1..x15, destinations from x16..x31, so no hazards
    repeat (20) begin
      f3    = $urandom % 8;
      rs1   = 1 + $urandom % 15;
      rs2   = 1 + $urandom % 15;
      rd    = 16 + $urandom % 16;
      imm12 = $urandom;
      if ($urandom % 2) begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ? 7'h20 : 7'h00;
        issue({f7, rs2, rs1, f3, rd, rv_dec_pkg::OP_OP}, "alu_reg");
      end else if (f3 == 3'd1 || f3 == 3'd5) begin
        f7 = (f3 == 3'd5 && ($urandom % 2)) ? 7'h20 : 7'h00; // SRAI
        issue({f7, imm12[4:0], rs1, f3, rd, rv_dec_pkg::OP_OPIMM}, "alu_shift");
      end else begin
        issue({imm12, rs1, f3, rd, rv_dec_pkg::OP_OPIMM}, "alu_imm");
      end
    end

    repeat (2) begin
      imm20 = $urandom;
      rd    = 16 + $urandom % 16;
      issue({imm20, rd, rv_dec_pkg::OP_LUI}, "lui");
      imm20 = $urandom;
      rd    = 16 + $urandom % 16;
      issue({imm20, rd, rv_dec_pkg::OP_AUIPC}, "auipc");
    end

    repeat (4) begin
      k     = $urandom % 5;
      f3    = (k < 3) ? k : k + 1; // LB LH LW LBU LHU
      rs1   = 1 + $urandom % 15;
      rd    = 16 + $urandom % 16;
      imm12 = $urandom;
      issue({imm12, rs1, f3, rd, rv_dec_pkg::OP_LOAD}, "load");
    end

    repeat (4) begin
      f3    = $urandom % 3;
      rs1   = 1 + $urandom % 15;
      rs2   = 1 + $urandom % 15;
      imm12 = $urandom;
      issue({imm12[11:5], rs2, rs1, f3, imm12[4:0], rv_dec_pkg::OP_STORE}, "store");
    end

    // Dependent chain, each reads the previous destination
    issue({12'd5, 5'd3, 3'b000, 5'd20, rv_dec_pkg::OP_OPIMM}, "dep_base");
    issue({7'h00, 5'd4, 5'd20, 3'b000, 5'd21, rv_dec_pkg::OP_OP}, "dep_rs1");
    issue({7'h00, 5'd21, 5'd6, 3'b111, 5'd22, rv_dec_pkg::OP_OP}, "dep_rs2");
    issue({12'h010, 5'd22, 3'b010, 5'd23, rv_dec_pkg::OP_LOAD}, "dep_load");
    issue({7'h00, 5'd23, 5'd7, 3'b010, 5'd8, rv_dec_pkg::OP_STORE}, "dep_store");
    issue({12'd1, 5'd2, 3'b000, 5'd0, rv_dec_pkg::OP_OPIMM}, "write_x0");
    issue({7'h00, 5'd0, 5'd0, 3'b000, 5'd9, rv_dec_pkg::OP_OP}, "read_x0");
    // Bits in the rs1 position match x9
    issue({20'hABC48, 5'd9, rv_dec_pkg::OP_LUI}, "lui_no_read");

    issue({25'h0, rv_dec_pkg::OP_BRANCH}, "illegal_branch");
    issue({20'h12345, 5'd1, rv_dec_pkg::OP_JAL}, "illegal_jal");
    issue(32'hFFFF_FFFF, "illegal_opcode");
    idle_gap(1, "idle_gap");
    issue({7'h00, 5'd5, 5'd6, 3'b001, 5'd12, rv_dec_pkg::OP_STORE}, "store_before_gap");
    idle_gap(1, "idle_gap");
    issue({20'h81234, 5'd18, rv_dec_pkg::OP_AUIPC}, "auipc_before_gap");
    idle_gap(3, "idle_gap");
    issue({12'h7FF, 5'd1, 3'b100, 5'd17, rv_dec_pkg::OP_OPIMM}, "after_gap");

    instr_valid = 1'b0;
    repeat (2) @(negedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("Not every expected cycle was checked, %0d left", exp_q.size());
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* rv_decoder.f */
+incdir+dv
common/rv_dec_pkg.sv
rtl/imm_gen.sv
rtl/hazard_unit.sv
rtl/mem_seq.sv
rtl/ctrl_decode.sv
rtl/rv_decoder.sv
dv/tb_clkgen.sv
dv/rv_decoder_tb.sv
